// File: Bender.yml
package:
  name: fetch

sources:
  # packages before the modules that use them
  - common/fetch_pkg.sv
  - common/bus_pkg.sv
  - icache/icache.sv
  - hdl/ram_ctrl.sv
  - hdl/fetch_unit.sv
  - hdl/fetch_top.sv
  - target: test
    files:
      - dv/wb_mem_model.sv
      - dv/fetch_tb.sv

// File: common/bus_pkg.sv
`default_nettype none

// external bus and refill stream types
package bus_pkg;

	// wishbone classic, master side
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic [31:0] adr;  // byte address
	} wb_m2s_t;

	// wishbone classic, slave side, 8-bit data
	typedef struct packed {
		logic       ack;
		logic [7:0] dat;
	} wb_s2m_t;

	// line request from the cache, held until the last byte
	typedef struct packed {
		logic        valid;
		logic [31:0] line_addr;  // 16-byte aligned
	} refill_req_t;

	// one byte of a line, in address order
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
		logic       last;  // 16th byte
	} refill_byte_t;

endpackage

`default_nettype wire

// File: common/fetch_pkg.sv
`default_nettype none

// types shared by the fetch unit and the instruction cache
package fetch_pkg;

	// cache geometry, 17 address bits in use
	localparam int INST_BIT   = 2;   // 4 instructions per line
	localparam int ROW_BIT    = 10;  // 1024 rows
	localparam int TAG_BIT    = 3;
	localparam int WAY_NUM    = 2;   // mru replacement only works for two ways
	localparam int BYTE_BIT   = 2;   // byte within an instruction
	localparam int LINE_BIT   = INST_BIT + BYTE_BIT;  // byte within a line
	localparam int UNUSED_BIT = 32 - TAG_BIT - ROW_BIT - LINE_BIT;
	localparam int ROW_NUM    = 1 << ROW_BIT;
	localparam int INST_NUM   = 1 << INST_BIT;

	// field view of a fetch address, msb first
	typedef struct packed {
		logic [UNUSED_BIT-1:0] unused;    // above the 17 bits the cache decodes
		logic [TAG_BIT-1:0]    tag;
		logic [ROW_BIT-1:0]    row;
		logic [INST_BIT-1:0]   inst;
		logic [BYTE_BIT-1:0]   byte_ofs;
	} fetch_addr_f_t;

	// one address word, read either whole or split into cache fields
	typedef union packed {
		logic [31:0]   word;
		fetch_addr_f_t f;
	} fetch_addr_u;

	typedef struct packed {
		logic        re;    // read enable
		fetch_addr_u addr;
	} fetch_req_t;

	typedef struct packed {
		logic        miss;  // same-cycle answer
		logic [31:0] data;
	} fetch_rsp_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] instr;
	} inst_t;

endpackage

`default_nettype wire

// File: dv/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

	// three lines on row 0x010 with tags 0, 1 and 2
	localparam logic [31:0] LINE_A   = 32'h0000_0100;
	localparam logic [31:0] LINE_B   = 32'h0000_4100;
	localparam logic [31:0] LINE_C   = 32'h0000_8100;
	localparam int          WAIT_MAX = 4000;

	logic                  clk;
	logic                  rst;
	logic                  redirect_valid;
	logic [31:0]           redirect_pc;
	logic                  inst_ready;
	logic [1:0]            ack_delay;
	fetch_pkg::inst_t      inst;
	bus_pkg::wb_m2s_t      wb_m2s;
	bus_pkg::wb_s2m_t      wb_s2m;

	logic [31:0] rnd_q;
	logic [31:0] exp_pc_q;     // pc the next accepted instruction must have
	logic [3:0]  ack_cnt_q;    // byte position inside the current refill
	logic [31:0] line_base_q;  // first address of the latest refill
	logic        quiet_q;      // no bus traffic allowed
	logic [31:0] prev_pc_q;
	logic [31:0] prev_instr_q;
	logic [31:0] prev_adr_q;
	logic        accepted;

	fetch_top #(
		.RESET_PC(LINE_A)
	) fetch_top_i (
		.clk              (clk),
		.rst_i            (rst),
		.redirect_valid_i (redirect_valid),
		.redirect_pc_i    (redirect_pc),
		.inst_o           (inst),
		.inst_ready_i     (inst_ready),
		.wb_o             (wb_m2s),
		.wb_i             (wb_s2m)
	);

	wb_mem_model mem_model_i (
		.clk     (clk),
		.rst_i   (rst),
		.delay_i (ack_delay),
		.wb_i    (wb_m2s),
		.wb_o    (wb_s2m)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [7:0] mem_byte(input logic [31:0] a);
		logic [31:0] m;
		m = a * 32'h9d;
		return m[7:0] + a[15:8] + a[23:16] + a[31:24];
	endfunction

	// byte 0 lands in bits 7:0 for little endian
	function automatic logic [31:0] word_at(input logic [31:0] pc);
		logic [31:0] w;
		for (int k = 0; k < 4; k++)
			w[8*k +: 8] = mem_byte(pc + k);
		return w;
	endfunction

	// tags 0..3 and rows from 0x200 up leave row 0x010 untouched
	function automatic logic [31:0] pick_target(input logic [31:0] r);
		return {15'd0, 1'b0, r[15:14], 1'b1, r[12:2], 2'b00};
	endfunction

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("Regression failed");
		$fatal(1);
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// one random word per cycle feeds ready, ack delay and redirects
	always @(posedge clk) begin
		rnd_q      <= xorshift32(rnd_q);
		inst_ready <= (rnd_q[1:0] != 2'b00);  // ready three cycles out of four
		ack_delay  <= rnd_q[3:2];
	end

	assign accepted = inst.valid && inst_ready;

	always @(posedge clk) begin
		prev_pc_q    <= inst.pc;
		prev_instr_q <= inst.instr;
		prev_adr_q   <= wb_m2s.adr;
		if (rst)
			exp_pc_q <= LINE_A;
		else if (redirect_valid)
			exp_pc_q <= redirect_pc;  // also wins over an accept in the same cycle
		else if (accepted)
			exp_pc_q <= exp_pc_q + 32'd4;
		if (rst) begin
			ack_cnt_q   <= 4'd0;
			line_base_q <= '0;
		end else if (wb_m2s.stb && wb_s2m.ack) begin
			ack_cnt_q <= ack_cnt_q + 4'd1;
			if (ack_cnt_q == 4'd0)
				line_base_q <= wb_m2s.adr;
		end
	end

	a_instr: assert property (@(posedge clk) disable iff (rst)
		accepted |-> inst.instr == word_at(inst.pc))
		else stop_with_failure($sformatf("Error inst_o.instr expected %h actual %h",
			word_at($sampled(inst.pc)), $sampled(inst.instr)));

	// sequential order, reset pc and redirect targets all come from exp_pc_q
	a_pc_order: assert property (@(posedge clk) disable iff (rst)
		accepted |-> inst.pc == exp_pc_q)
		else stop_with_failure($sformatf("Error inst_o.pc expected %h actual %h",
			$sampled(exp_pc_q), $sampled(inst.pc)));

	a_stb_cyc: assert property (@(posedge clk) disable iff (rst)
		wb_m2s.stb |-> wb_m2s.cyc)
		else stop_with_failure("stb was high while cyc was low");

	a_adr_hold: assert property (@(posedge clk) disable iff (rst)
		wb_m2s.stb && !wb_s2m.ack |=> wb_m2s.stb && wb_m2s.adr == prev_adr_q)
		else stop_with_failure($sformatf("Error wb_o.adr expected %h actual %h",
			$sampled(prev_adr_q), $sampled(wb_m2s.adr)));

	// 16 consecutive reads per line starting on a 16-byte boundary
	a_adr_order: assert property (@(posedge clk) disable iff (rst)
		wb_m2s.stb && wb_s2m.ack |-> wb_m2s.adr[3:0] == ack_cnt_q
			&& (ack_cnt_q == 4'd0 || wb_m2s.adr[31:4] == line_base_q[31:4]))
		else stop_with_failure($sformatf("Error wb_o.adr expected %h actual %h",
			{$sampled(line_base_q[31:4]), $sampled(ack_cnt_q)}, $sampled(wb_m2s.adr)));

	a_no_refill: assert property (@(posedge clk) disable iff (rst)
		quiet_q |-> !wb_m2s.cyc)
		else stop_with_failure("bus cycle started for a line that should be cached");

	a_third_line: assert property (@(posedge clk) disable iff (rst)
		accepted && inst.pc == LINE_C |-> line_base_q == LINE_C)
		else stop_with_failure($sformatf("Error wb_o.adr expected %h actual %h",
			LINE_C, $sampled(line_base_q)));

	a_stall_hold: assert property (@(posedge clk) disable iff (rst)
		inst.valid && !inst_ready && !redirect_valid
		|=> inst.valid && inst.pc == prev_pc_q && inst.instr == prev_instr_q)
		else stop_with_failure($sformatf("Error inst_o.pc/instr expected %h/%h actual %h/%h",
			$sampled(prev_pc_q), $sampled(prev_instr_q),
			$sampled(inst.pc), $sampled(inst.instr)));

	task automatic redirect_to(input logic [31:0] target);
		redirect_valid <= 1'b1;
		redirect_pc    <= target;
		@(posedge clk);
		redirect_valid <= 1'b0;
	endtask

	// wait until last_pc is taken and jump before the pc leaves the line
	task automatic fetch_until(input logic [31:0] last_pc, input logic [31:0] next_pc,
		input logic quiet);
		int  n;
		logic seen;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < WAIT_MAX) begin
			@(posedge clk);
			seen = accepted && (inst.pc == last_pc);
			n++;
		end
		if (!seen)
			stop_with_failure($sformatf("timeout waiting for pc %h to be accepted", last_pc));
		quiet_q <= quiet;
		redirect_to(next_pc);
	endtask

	task automatic wait_accepts(input int count);
		int n;
		int got;
		n   = 0;
		got = 0;
		while (got < count && n < WAIT_MAX) begin
			@(posedge clk);
			if (accepted)
				got++;
			n++;
		end
		if (got < count)
			stop_with_failure("timeout waiting for instructions to be accepted");
	endtask

	initial begin
		rst            = 1'b1;
		redirect_valid = 1'b0;
		redirect_pc    = '0;
		inst_ready     = 1'b0;
		ack_delay      = 2'd0;
		quiet_q        = 1'b0;
		rnd_q          = 32'he1ad_8a08;
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		// two lines in one row that both stay cached
		fetch_until(LINE_A + 32'd8, LINE_B, 1'b0);
		fetch_until(LINE_B + 32'd8, LINE_A, 1'b1);
		fetch_until(LINE_A + 32'd8, LINE_B, 1'b1);
		fetch_until(LINE_B + 32'd8, LINE_A, 1'b1);
		// third line evicts B since A was used last
		fetch_until(LINE_A + 32'd8, LINE_C, 1'b0);
		fetch_until(LINE_C + 32'd8, LINE_A, 1'b1);
		fetch_until(LINE_A + 32'd8, pick_target(rnd_q), 1'b0);

		// random jumps with some in the middle of a refill
		for (int i = 0; i < 30; i++) begin
			if (rnd_q[8:7] == 2'b00)
				repeat (rnd_q[6:4]) @(posedge clk);
			else
				wait_accepts(1 + rnd_q[6:4]);
			redirect_to(pick_target(rnd_q));
		end
		wait_accepts(8);

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/wb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

// wishbone classic byte memory, contents follow an address rule
// ack comes 0 to 3 cycles after stb, as chosen by delay_i
module wb_mem_model (
	input  wire                   clk,
	input  wire                   rst_i,
	input  wire [1:0]             delay_i,  // only looked at in the first cycle of a read
	input  wire bus_pkg::wb_m2s_t wb_i,
	output bus_pkg::wb_s2m_t      wb_o
);

	logic [1:0] wait_q;   // cycles this read has waited so far
	logic [1:0] delay_q;  // delay picked for the running read
	logic [1:0] delay;
	logic       ack;

	// low byte of a * 0x9d plus the upper address bytes
	function automatic logic [7:0] byte_at(input logic [31:0] a);
		logic [31:0] m;
		m = a * 32'h9d;
		return m[7:0] + a[15:8] + a[23:16] + a[31:24];
	endfunction

	assign delay = (wait_q == 2'd0) ? delay_i : delay_q;
	assign ack   = wb_i.cyc && wb_i.stb && (wait_q == delay);  // zero delay acks at once

	assign wb_o = '{ack: ack, dat: byte_at(wb_i.adr)};

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wait_q  <= 2'd0;
			delay_q <= 2'd0;
		end else if (wb_i.cyc && wb_i.stb && !ack) begin
			wait_q <= wait_q + 2'd1;
			if (wait_q == 2'd0)
				delay_q <= delay_i;  // hold the choice until the ack
		end else begin
			wait_q <= 2'd0;
		end
	end

endmodule

`default_nettype wire

// File: fetch.f
common/fetch_pkg.sv
common/bus_pkg.sv
icache/icache.sv
hdl/ram_ctrl.sv
hdl/fetch_unit.sv
hdl/fetch_top.sv
dv/wb_mem_model.sv
dv/fetch_tb.sv

// File: hdl/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

// instruction fetch subsystem
// fetch unit -> icache -> refill controller -> wishbone
module fetch_top #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  wire                   clk,
	input  wire                   rst_i,
	input  wire                   redirect_valid_i,
	input  wire [31:0]            redirect_pc_i,
	output fetch_pkg::inst_t      inst_o,
	input  wire                   inst_ready_i,
	output bus_pkg::wb_m2s_t      wb_o,
	input  wire bus_pkg::wb_s2m_t wb_i
);

	fetch_pkg::fetch_req_t fetch_req;    // pc lookup
	fetch_pkg::fetch_rsp_t fetch_rsp;    // same-cycle hit or miss
	bus_pkg::refill_req_t  refill_req;
	bus_pkg::refill_byte_t refill_byte;

	fetch_unit #(
		.RESET_PC(RESET_PC)
	) fetch_unit_i (
		.clk              (clk),
		.rst_i            (rst_i),
		.redirect_valid_i (redirect_valid_i),
		.redirect_pc_i    (redirect_pc_i),
		.req_o            (fetch_req),
		.rsp_i            (fetch_rsp),
		.inst_o           (inst_o),
		.inst_ready_i     (inst_ready_i)
	);

	icache icache_i (
		.clk      (clk),
		.rst_i    (rst_i),
		.req_i    (fetch_req),
		.rsp_o    (fetch_rsp),
		.refill_o (refill_req),
		.byte_i   (refill_byte)
	);

	ram_ctrl ram_ctrl_i (
		.clk      (clk),
		.rst_i    (rst_i),
		.refill_i (refill_req),
		.byte_o   (refill_byte),
		.wb_o     (wb_o),
		.wb_i     (wb_i)
	);

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

// program counter and registered instruction output
module fetch_unit #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  wire                        clk,
	input  wire                        rst_i,
	input  wire                        redirect_valid_i,
	input  wire [31:0]                 redirect_pc_i,
	output fetch_pkg::fetch_req_t      req_o,
	input  wire fetch_pkg::fetch_rsp_t rsp_i,
	output fetch_pkg::inst_t           inst_o,
	input  wire                        inst_ready_i
);

	fetch_pkg::fetch_addr_u pc_q;
	logic                   out_free;  // output empty or taken this cycle
	logic                   load;      // hit goes into the output register
	logic                   inst_valid_q;
	logic [31:0]            inst_pc_q;
	logic [31:0]            inst_word_q;

	// the current pc is dropped on a redirect, so it must not start a refill
	assign req_o = '{re: !redirect_valid_i, addr: pc_q};

	assign out_free = !inst_valid_q || inst_ready_i;
	assign load     = req_o.re && !rsp_i.miss && out_free;

	// pc and output valid
	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc_q.word    <= RESET_PC;
			inst_valid_q <= 1'b0;
		end else if (redirect_valid_i) begin
			pc_q.word    <= redirect_pc_i;  // wins over a hit
			inst_valid_q <= 1'b0;           // anything not yet taken is lost
		end else if (load) begin
			pc_q.word    <= pc_q.word + 32'd4;
			inst_valid_q <= 1'b1;
		end else if (inst_ready_i) begin
			inst_valid_q <= 1'b0;
		end
	end

	// payload, only moves on a load
	always_ff @(posedge clk) begin
		if (load) begin
			inst_pc_q   <= pc_q.word;
			inst_word_q <= rsp_i.data;
		end
	end

	assign inst_o = '{valid: inst_valid_q, pc: inst_pc_q, instr: inst_word_q};

	// stalled output holds until taken or flushed by a redirect
	a_inst_hold: assert property (@(posedge clk) disable iff (rst_i)
		inst_o.valid && !inst_ready_i && !redirect_valid_i
		|=> inst_o.valid && $stable(inst_o.pc) && $stable(inst_o.instr));

endmodule

`default_nettype wire

// File: hdl/ram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// line refill over an 8-bit wishbone classic bus
// 16 single-byte reads per request with one idle cycle between reads
module ram_ctrl (
	input  wire                        clk,
	input  wire                        rst_i,
	input  wire bus_pkg::refill_req_t  refill_i,
	output bus_pkg::refill_byte_t      byte_o,
	output bus_pkg::wb_m2s_t           wb_o,
	input  wire bus_pkg::wb_s2m_t      wb_i
);

	typedef enum logic {
		B_IDLE,
		B_CYC
	} bus_state_e;

	bus_state_e                     state_q;
	logic [fetch_pkg::LINE_BIT-1:0] cnt_q;   // next byte of the line and wraps after 16
	logic                           hold_q;  // line done and waiting for the request to drop
	logic                           take;    // byte acked this cycle
	logic                           last;
	fetch_pkg::fetch_addr_u         adr;
	logic                           byte_valid_q;
	logic [7:0]                     byte_data_q;
	logic                           byte_last_q;

	assign take = (state_q == B_CYC) && wb_i.ack;
	assign last = (cnt_q == '1);

	// byte address = line address with the counter in the low bits
	always_comb begin
		adr.word                    = refill_i.line_addr;
		{adr.f.inst, adr.f.byte_ofs} = cnt_q;
	end

	assign wb_o = '{cyc: (state_q == B_CYC), stb: (state_q == B_CYC), adr: adr.word};

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= B_IDLE;
			cnt_q   <= '0;
			hold_q  <= 1'b0;
		end else begin
			case (state_q)
				B_IDLE: begin
					// also the one-cycle gap after each ack
					if (refill_i.valid && !hold_q)
						state_q <= B_CYC;
				end
				B_CYC: begin
					if (wb_i.ack) begin
						state_q <= B_IDLE;
						cnt_q   <= cnt_q + 1'b1;
					end
				end
				default: state_q <= B_IDLE;
			endcase
			if (take && last)
				hold_q <= 1'b1;
			else if (!refill_i.valid)
				hold_q <= 1'b0;  // ready for the next request
		end
	end

	// each acked byte goes onto the stream one cycle later
	always_ff @(posedge clk) begin
		if (rst_i)
			byte_valid_q <= 1'b0;
		else
			byte_valid_q <= take;
	end

	always_ff @(posedge clk) begin
		if (take) begin
			byte_data_q <= wb_i.dat;
			byte_last_q <= last;
		end
	end

	assign byte_o = '{valid: byte_valid_q, data: byte_data_q, last: byte_last_q};

	// classic cycle holds its address until the slave acks
	a_adr_hold: assert property (@(posedge clk) disable iff (rst_i)
		wb_o.stb && !wb_i.ack |=> wb_o.stb && $stable(wb_o.adr));

endmodule

`default_nettype wire

// File: icache/icache.sv
`timescale 1ns/1ps
`default_nettype none

// two-way set-associative read-only instruction cache
// lookup is combinational, fills come in as a byte stream
module icache (
	input  wire                        clk,
	input  wire                        rst_i,
	input  wire fetch_pkg::fetch_req_t req_i,
	output fetch_pkg::fetch_rsp_t      rsp_o,
	output bus_pkg::refill_req_t       refill_o,
	input  wire bus_pkg::refill_byte_t byte_i
);

	typedef enum logic {
		S_IDLE,
		S_FILL
	} state_e;

	// storage, indexed row / way / instruction
	logic [31:0] data_mem
		[fetch_pkg::ROW_NUM][fetch_pkg::WAY_NUM][fetch_pkg::INST_NUM];
	logic [fetch_pkg::TAG_BIT-1:0] tag_mem [fetch_pkg::ROW_NUM][fetch_pkg::WAY_NUM];
	logic [fetch_pkg::ROW_NUM-1:0][fetch_pkg::WAY_NUM-1:0] valid_q;
	logic [fetch_pkg::ROW_NUM-1:0] mru_q;  // way used last, per row

	fetch_pkg::fetch_addr_u        addr;       // lookup address
	fetch_pkg::fetch_addr_u        miss_line;  // lookup address, line aligned
	logic [fetch_pkg::WAY_NUM-1:0] hit_way;    // one bit per way
	logic                          hit;
	logic                          hit_idx;    // way that matched
	logic                          miss;

	state_e                         state_q;
	fetch_pkg::fetch_addr_u         fill_line_q;  // line being filled
	logic                           victim_q;     // way being filled
	logic [fetch_pkg::LINE_BIT-1:0] bcnt_q;       // byte position in the line
	logic [31:0]                    fill_word_q;  // word under assembly
	logic [31:0]                    fill_word;

	assign addr = req_i.addr;

	// compare tag and valid of every way at the row
	always_comb begin
		hit_idx = 1'b0;
		for (int w = 0; w < fetch_pkg::WAY_NUM; w++) begin
			hit_way[w] = valid_q[addr.f.row][w] && (tag_mem[addr.f.row][w] == addr.f.tag);
			if (hit_way[w])
				hit_idx = w[0];
		end
	end

	assign hit  = |hit_way;
	assign miss = req_i.re && !hit;  // no read, no miss

	assign rsp_o = '{miss: miss, data: data_mem[addr.f.row][hit_idx][addr.f.inst]};

	// refill always starts at byte 0 of the line
	always_comb begin
		miss_line            = addr;
		miss_line.f.inst     = '0;
		miss_line.f.byte_ofs = '0;
	end

	assign refill_o = '{valid: (state_q == S_FILL), line_addr: fill_line_q.word};

	// little endian, so each new byte goes in on top and the rest shift down
	assign fill_word = {byte_i.data, fill_word_q[31:8]};

	// control: fsm, valid and mru bits
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= S_IDLE;
			bcnt_q  <= '0;
			valid_q <= '0;
			mru_q   <= '0;
		end else begin
			if (req_i.re && hit)
				mru_q[addr.f.row] <= hit_idx;  // refresh on every hit
			case (state_q)
				S_IDLE: begin
					if (miss) begin
						state_q <= S_FILL;  // request goes out next cycle
						bcnt_q  <= '0;
						// the victim stops hitting while its words are overwritten
						valid_q[addr.f.row][!mru_q[addr.f.row]] <= 1'b0;
					end
				end
				S_FILL: begin
					if (byte_i.valid) begin
						bcnt_q <= bcnt_q + 1'b1;
						if (byte_i.last) begin
							valid_q[fill_line_q.f.row][victim_q] <= 1'b1;  // miss clears next cycle
							mru_q[fill_line_q.f.row]             <= victim_q;
							state_q                              <= S_IDLE;
						end
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// line data, tags and fill bookkeeping
	always_ff @(posedge clk) begin
		if (state_q == S_IDLE && miss) begin
			fill_line_q <= miss_line;
			victim_q    <= ~mru_q[addr.f.row];  // replace the other way
		end
		if (state_q == S_FILL && byte_i.valid) begin
			fill_word_q <= fill_word;
			// fourth byte completes a word
			if (bcnt_q[fetch_pkg::BYTE_BIT-1:0] == '1)
				data_mem[fill_line_q.f.row][victim_q][bcnt_q[fetch_pkg::LINE_BIT-1:fetch_pkg::BYTE_BIT]]
					<= fill_word;
			if (byte_i.last)
				tag_mem[fill_line_q.f.row][victim_q] <= fill_line_q.f.tag;
		end
	end

	// the controller only streams bytes for an open request
	a_byte_in_refill: assert property (@(posedge clk) disable iff (rst_i)
		byte_i.valid |-> refill_o.valid);

	// request held steady until its last byte has been seen
	a_refill_stable: assert property (@(posedge clk) disable iff (rst_i)
		refill_o.valid && !(byte_i.valid && byte_i.last)
		|=> refill_o.valid && $stable(refill_o.line_addr));

endmodule

`default_nettype wire
